// File: compile.f
common/pred_pkg.sv
common/pred_way_if.sv
pred_cache/pred_way_ram.sv
pred_cache/pred_replace.sv
pred_cache/pred_cache.sv
hw/pred_init_fsm.sv
hw/pred_top.sv
testbench/pred_assertions.sv
testbench/tb_pred_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_pred_top \
    -f compile.f -o sim_pred

./obj_dir/sim_pred 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without failures"

// File: testbench/tb_pred_top.sv
`timescale 1ns/100ps

module tb_pred_top;

    localparam int aw   = pred_pkg::ADDR_WIDTH_DEF;
    localparam int tw   = pred_pkg::TAG_WIDTH_DEF;
    localparam int hw   = pred_pkg::H_WIDTH_DEF;
    localparam int way  = pred_pkg::WAYS_DEF;
    localparam int sets = 1 << aw;
    localparam int ctrs = 1 << hw;

    localparam int rand_cycles     = 400;
    localparam int directed_cycles = sets + 200;
    localparam int timeout_cycles  = 2 * (4 + sets + directed_cycles + rand_cycles);

    logic          clk;
    logic          arst_n;
    logic          lookup_en;
    logic [aw-1:0] lookup_addr;
    logic [tw-1:0] lookup_tag;
    logic [hw-1:0] lookup_h;
    logic          pred_valid;
    logic [1:0]    pred_ctr;
    logic          update_en;
    logic [aw-1:0] update_addr;
    logic [tw-1:0] update_tag;
    logic [hw-1:0] update_h;
    logic          update_taken;
    logic          ready;

    // reference model state
    logic          m_valid [sets][way];
    logic [tw-1:0] m_tag   [sets][way];
    logic [1:0]    m_ctr   [sets][way][ctrs];
    int            m_ptr   [sets];

    // update sampled at the last edge, written at the next one
    logic          pend_en;
    logic [aw-1:0] pend_addr;
    logic [tw-1:0] pend_tag;
    logic [hw-1:0] pend_h;
    logic          pend_taken;

    logic [1:0]    exp_q [$];
    logic [1:0]    exp_ctr;
    int            errors;
    int            checks;
    logic [31:0]   rng;

    pred_top #(
        .addr_width(aw),
        .tag_width (tw),
        .h_width   (hw),
        .way       (way)
    ) UUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .lookup_en   (lookup_en),
        .lookup_addr (lookup_addr),
        .lookup_tag  (lookup_tag),
        .lookup_h    (lookup_h),
        .pred_valid  (pred_valid),
        .pred_ctr    (pred_ctr),
        .update_en   (update_en),
        .update_addr (update_addr),
        .update_tag  (update_tag),
        .update_h    (update_h),
        .update_taken(update_taken),
        .ready       (ready)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [1:0] sat_step(input logic [1:0] c, input logic taken);
        if (taken) begin
            return (c == 2'b11) ? c : c + 2'b01;
        end
        return (c == 2'b00) ? c : c - 2'b01;
    endfunction

    // lowest valid matching way, 00 on a miss
    function automatic logic [1:0] predict(input logic [aw-1:0] a, input logic [tw-1:0] t,
                                           input logic [hw-1:0] h);
        for (int w = 0; w < way; w++) begin
            if (m_valid[a][w] && m_tag[a][w] == t) begin
                return m_ctr[a][w][h];
            end
        end
        return 2'b00;
    endfunction

    task automatic commit_update(input logic [aw-1:0] a, input logic [tw-1:0] t,
                                 input logic [hw-1:0] h, input logic taken);
        int hit;
        int inv;
        int sel;
        hit = -1;
        inv = -1;
        for (int w = 0; w < way; w++) begin
            if (hit < 0 && m_valid[a][w] && m_tag[a][w] == t) begin
                hit = w;
            end
            if (inv < 0 && !m_valid[a][w]) begin
                inv = w;
            end
        end
        if (hit >= 0) begin
            sel = hit;
        end else begin
            if (inv >= 0) begin
                sel = inv;
            end else begin
                sel      = m_ptr[a];  // evict, round robin
                m_ptr[a] = (m_ptr[a] + 1) % way;
            end
            m_valid[a][sel] = 1'b1;
            m_tag[a][sel]   = t;
            for (int c = 0; c < ctrs; c++) begin
                m_ctr[a][sel][c] = 2'b00;
            end
        end
        m_ctr[a][sel][h] = sat_step(m_ctr[a][sel][h], taken);
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error @ %0t: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic drive_cycle(input logic lk, input logic [aw-1:0] la, input logic [tw-1:0] lt,
                               input logic [hw-1:0] lh, input logic up, input logic [aw-1:0] ua,
                               input logic [tw-1:0] ut, input logic [hw-1:0] uh,
                               input logic tk);
        lookup_en    = lk;
        lookup_addr  = la;
        lookup_tag   = lt;
        lookup_h     = lh;
        update_en    = up;
        update_addr  = ua;
        update_tag   = ut;
        update_h     = uh;
        update_taken = tk;
        // a lookup at this edge still sees the data before the pending write
        if (lk) begin
            exp_q.push_back(predict(la, lt, lh));
        end
        if (pend_en) begin
            commit_update(pend_addr, pend_tag, pend_h, pend_taken);
        end
        pend_en    = up;
        pend_addr  = ua;
        pend_tag   = ut;
        pend_h     = uh;
        pend_taken = tk;
        @(posedge clk);
        #2;
    endtask

    task automatic idle();
        drive_cycle(1'b0, '0, '0, '0, 1'b0, '0, '0, '0, 1'b0);
    endtask

    task automatic probe(input logic [aw-1:0] a, input logic [tw-1:0] t, input logic [hw-1:0] h);
        drive_cycle(1'b1, a, t, h, 1'b0, '0, '0, '0, 1'b0);
    endtask

    task automatic send_update(input logic [aw-1:0] a, input logic [tw-1:0] t,
                               input logic [hw-1:0] h, input logic tk);
        drive_cycle(1'b0, '0, '0, '0, 1'b1, a, t, h, tk);
    endtask

    task automatic step_and_probe(input logic [aw-1:0] a, input logic [tw-1:0] t,
                                  input logic [hw-1:0] h, input logic tk);
        send_update(a, t, h, tk);
        idle();
        probe(a, t, h);
    endtask

    // compare each prediction in the cycle after its lookup
    always @(negedge clk) begin
        if (pred_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("pred_valid pulsed with no lookup outstanding at %0t", $time);
            end else begin
                exp_ctr = exp_q.pop_front();
                check(32'(pred_ctr), 32'(exp_ctr), "pred_ctr");
            end
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int n;
        clk          = 1'b0;
        arst_n       = 1'b0;
        lookup_en    = 1'b0;
        lookup_addr  = '0;
        lookup_tag   = '0;
        lookup_h     = '0;
        update_en    = 1'b0;
        update_addr  = '0;
        update_tag   = '0;
        update_h     = '0;
        update_taken = 1'b0;
        pend_en      = 1'b0;
        errors       = 0;
        checks       = 0;
        rng          = 32'heae0e068;
        for (int s = 0; s < sets; s++) begin
            m_ptr[s] = 0;
            for (int w = 0; w < way; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w]   = '0;
                for (int c = 0; c < ctrs; c++) begin
                    m_ctr[s][w][c] = 2'b00;
                end
            end
        end

        repeat (2) @(posedge clk);
        #2;
        arst_n = 1'b1;
        check(32'(ready), 0, "ready at reset release");

        // strobes held high through the sweep must be dropped
        lookup_en    = 1'b1;
        update_en    = 1'b1;
        update_taken = 1'b1;
        n = 0;
        while (!ready && n < sets + 8) begin
            @(posedge clk);
            #2;
            n++;
        end
        check(n, sets, "cycles from reset release to ready");

        // every set reads as a miss after the sweep
        for (int s = 0; s < sets; s++) begin
            rng = xorshift32(rng);
            probe(aw'(s), rng[tw-1:0], rng[tw+hw-1:tw]);
        end
        probe(aw'(0), '0, '0);  // no entry left by the sweep-time update

        // saturate up, then walk back down
        for (int i = 0; i < 4; i++) begin
            step_and_probe(aw'(5), tw'(10'h155), hw'(3), 1'b1);
        end
        for (int i = 0; i < 4; i++) begin
            step_and_probe(aw'(5), tw'(10'h155), hw'(3), 1'b0);
        end

        // independent counters in one entry, then a second tag in the set
        step_and_probe(aw'(5), tw'(10'h155), hw'(7), 1'b1);
        step_and_probe(aw'(5), tw'(10'h155), hw'(7), 1'b1);
        step_and_probe(aw'(5), tw'(10'h155), hw'(8), 1'b0);
        probe(aw'(5), tw'(10'h155), hw'(3));
        probe(aw'(5), tw'(10'h155), hw'(7));
        step_and_probe(aw'(5), tw'(10'h2aa), hw'(7), 1'b1);
        probe(aw'(5), tw'(10'h155), hw'(7));
        probe(aw'(5), tw'(10'h155), hw'(8));

        // overfill one set, back to back updates per tag
        for (int i = 0; i < way + 2; i++) begin
            send_update(aw'(9), tw'(10'h040 + i), hw'(0), 1'b1);
            send_update(aw'(9), tw'(10'h040 + i), hw'(0), 1'b1);
        end
        idle();
        for (int i = 0; i < way + 2; i++) begin
            probe(aw'(9), tw'(10'h040 + i), hw'(0));
        end

        // random traffic on a few sets, updates to set 2 every cycle at first
        for (int i = 0; i < rand_cycles; i++) begin
            rng = xorshift32(rng);
            drive_cycle(rng[0], aw'(rng[3:1] % 3), tw'(rng[6:4]), hw'(rng[8:7]),
                        (i < 50) | rng[9] | rng[10], aw'((i < 50) ? 2 : rng[13:11] % 3),
                        tw'(rng[16:14]), hw'(rng[18:17]), rng[19]);
        end
        repeat (3) idle();
        check(exp_q.size(), 0, "lookups left without a prediction");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/pred_assertions.sv
`timescale 1ns/100ps

module pred_assertions #(
    parameter int way = pred_pkg::WAYS_DEF
) (
    input logic           clk,
    input logic           arst_n,
    input logic           lookup_en,
    input logic           clear_en,
    input logic           pred_valid,
    input logic           upd_vld_q,
    input logic [way-1:0] we_vec,
    input logic           wr_valid
);

    // an update writes a single way
    assert property (@(posedge clk) disable iff (!arst_n)
        !clear_en |-> $onehot0(we_vec))
        else $error("more than one way written by one update");

    assert property (@(posedge clk) disable iff (!arst_n)
        pred_valid == $past(lookup_en && !clear_en))
        else $error("pred_valid does not follow lookup_en by one cycle");

    // sweep owns the write port
    assert property (@(posedge clk) disable iff (!arst_n)
        clear_en |-> (&we_vec && !wr_valid && !upd_vld_q))
        else $error("write other than a clear during the init sweep");

endmodule

bind pred_cache pred_assertions #(.way(way)) u_assertions (
    .clk       (clk),
    .arst_n    (arst_n),
    .lookup_en (lookup_en),
    .clear_en  (clear_en),
    .pred_valid(pred_valid),
    .upd_vld_q (upd_vld_q),
    .we_vec    (we_vec),
    .wr_valid  (wr_valid)
);

// File: hw/pred_top.sv
`timescale 1ns/100ps

module pred_top #(
    parameter int addr_width = pred_pkg::ADDR_WIDTH_DEF,
    parameter int tag_width  = pred_pkg::TAG_WIDTH_DEF,
    parameter int h_width    = pred_pkg::H_WIDTH_DEF,
    parameter int way        = pred_pkg::WAYS_DEF
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  lookup_en,
    input  logic [addr_width-1:0] lookup_addr,
    input  logic [tag_width-1:0]  lookup_tag,
    input  logic [h_width-1:0]    lookup_h,
    output logic                  pred_valid,
    output pred_pkg::ctr_t        pred_ctr,
    input  logic                  update_en,
    input  logic [addr_width-1:0] update_addr,
    input  logic [tag_width-1:0]  update_tag,
    input  logic [h_width-1:0]    update_h,
    input  logic                  update_taken,
    output logic                  ready
);

    logic                  clear_en;
    logic [addr_width-1:0] clear_addr;

    pred_init_fsm #(
        .addr_width(addr_width)
    ) u_init (
        .clk       (clk),
        .arst_n    (arst_n),
        .clear_en  (clear_en),
        .clear_addr(clear_addr),
        .ready     (ready)
    );

    pred_cache #(
        .addr_width(addr_width),
        .tag_width (tag_width),
        .h_width   (h_width),
        .way       (way)
    ) u_cache (
        .clk         (clk),
        .arst_n      (arst_n),
        .lookup_en   (lookup_en),
        .lookup_addr (lookup_addr),
        .lookup_tag  (lookup_tag),
        .lookup_h    (lookup_h),
        .update_en   (update_en),
        .update_addr (update_addr),
        .update_tag  (update_tag),
        .update_h    (update_h),
        .update_taken(update_taken),
        .clear_en    (clear_en),
        .clear_addr  (clear_addr),
        .pred_valid  (pred_valid),
        .pred_ctr    (pred_ctr)
    );

endmodule

// File: hw/pred_init_fsm.sv
`timescale 1ns/100ps

module pred_init_fsm #(
    parameter int addr_width = pred_pkg::ADDR_WIDTH_DEF
) (
    input  logic                  clk,
    input  logic                  arst_n,
    output logic                  clear_en,
    output logic [addr_width-1:0] clear_addr,
    output logic                  ready
);

    typedef enum logic {
        st_sweep,
        st_run
    } state_t;

    state_t state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= st_sweep;
            clear_addr <= '0;
        end else if (state == st_sweep) begin
            clear_addr <= clear_addr + 1'b1;
            if (&clear_addr) begin
                state <= st_run;  // last set cleared this edge
            end
        end
    end

    // one set cleared per cycle while sweeping
    assign clear_en = (state == st_sweep);
    assign ready    = (state == st_run);

endmodule

// File: pred_cache/pred_cache.sv
`timescale 1ns/100ps

module pred_cache #(
    parameter int addr_width = pred_pkg::ADDR_WIDTH_DEF,
    parameter int tag_width  = pred_pkg::TAG_WIDTH_DEF,
    parameter int h_width    = pred_pkg::H_WIDTH_DEF,
    parameter int way        = pred_pkg::WAYS_DEF
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  lookup_en,
    input  logic [addr_width-1:0] lookup_addr,
    input  logic [tag_width-1:0]  lookup_tag,
    input  logic [h_width-1:0]    lookup_h,
    input  logic                  update_en,
    input  logic [addr_width-1:0] update_addr,
    input  logic [tag_width-1:0]  update_tag,
    input  logic [h_width-1:0]    update_h,
    input  logic                  update_taken,
    input  logic                  clear_en,
    input  logic [addr_width-1:0] clear_addr,
    output logic                  pred_valid,
    output pred_pkg::ctr_t        pred_ctr
);

    localparam int ctrs   = 1 << h_width;
    localparam int wsel_w = $clog2(way);

    // lookup side
    logic [tag_width-1:0]      lkp_tag_q;
    logic [h_width-1:0]        lkp_h_q;
    logic [way-1:0]            r_valid;
    logic [tag_width-1:0]      r_tag [way];
    pred_pkg::ctr_t [ctrs-1:0] r_ctrs [way];

    // update stage 2
    logic                      upd_vld_q;
    logic [addr_width-1:0]     upd_addr_q;
    logic [tag_width-1:0]      upd_tag_q;
    logic [h_width-1:0]        upd_h_q;
    logic                      upd_taken_q;
    logic [way-1:0]            e_valid;
    logic [tag_width-1:0]      e_tag [way];
    pred_pkg::ctr_t [ctrs-1:0] e_ctrs [way];
    logic                      any_hit, any_inv;
    logic [wsel_w-1:0]         hit_idx, inv_idx, sel, repl_way;
    pred_pkg::ctr_t [ctrs-1:0] base_ctrs, new_ctrs;
    logic                      repl_step;

    // shared write port
    logic [way-1:0]            we_vec;
    logic [addr_width-1:0]     wr_addr;
    logic                      wr_valid;
    logic [tag_width-1:0]      wr_tag;
    pred_pkg::ctr_t [ctrs-1:0] wr_ctrs;

    // last write, replayed into a same-set read
    logic                      byp_en;
    logic [way-1:0]            byp_we;
    logic                      byp_valid;
    logic [tag_width-1:0]      byp_tag;
    pred_pkg::ctr_t [ctrs-1:0] byp_ctrs;

    for (genvar i = 0; i < way; i++) begin : g_way
        pred_way_if #(
            .addr_width(addr_width),
            .tag_width (tag_width),
            .h_width   (h_width)
        ) wif ();

        pred_way_ram #(
            .addr_width(addr_width),
            .tag_width (tag_width),
            .h_width   (h_width)
        ) u_ram (
            .clk(clk),
            .wp (wif.ram)
        );

        assign wif.raddr  = lookup_addr;
        assign wif.uaddr  = update_addr;
        assign wif.waddr  = wr_addr;
        assign wif.we     = we_vec[i];
        assign wif.wvalid = wr_valid;
        assign wif.wtag   = wr_tag;
        assign wif.wctrs  = wr_ctrs;

        assign r_valid[i] = wif.rvalid;
        assign r_tag[i]   = wif.rtag;
        assign r_ctrs[i]  = wif.rctrs;

        assign e_valid[i] = (byp_en && byp_we[i]) ? byp_valid : wif.uvalid;
        assign e_tag[i]   = (byp_en && byp_we[i]) ? byp_tag   : wif.utag;
        assign e_ctrs[i]  = (byp_en && byp_we[i]) ? byp_ctrs  : wif.uctrs;
    end

    pred_replace #(
        .addr_width(addr_width),
        .way       (way)
    ) u_replace (
        .clk      (clk),
        .arst_n   (arst_n),
        .repl_addr(upd_addr_q),
        .repl_step(repl_step),
        .repl_way (repl_way)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pred_valid <= 1'b0;
            upd_vld_q  <= 1'b0;
            byp_en     <= 1'b0;
        end else begin
            pred_valid <= lookup_en && !clear_en;  // strobes dropped during sweep
            upd_vld_q  <= update_en && !clear_en;
            byp_en     <= (|we_vec) && (wr_addr == update_addr);
        end
    end

    always_ff @(posedge clk) begin
        lkp_tag_q   <= lookup_tag;
        lkp_h_q     <= lookup_h;
        upd_addr_q  <= update_addr;
        upd_tag_q   <= update_tag;
        upd_h_q     <= update_h;
        upd_taken_q <= update_taken;
        byp_we      <= we_vec;
        byp_valid   <= wr_valid;
        byp_tag     <= wr_tag;
        byp_ctrs    <= wr_ctrs;
    end

    // lowest valid matching way wins
    always_comb begin
        pred_ctr = pred_pkg::CTR_INIT;
        for (int i = way - 1; i >= 0; i--) begin
            if (r_valid[i] && r_tag[i] == lkp_tag_q) begin
                pred_ctr = r_ctrs[i][lkp_h_q];
            end
        end
    end

    always_comb begin
        any_hit = 1'b0;
        any_inv = 1'b0;
        hit_idx = '0;
        inv_idx = '0;
        for (int i = way - 1; i >= 0; i--) begin
            if (e_valid[i] && e_tag[i] == upd_tag_q) begin
                any_hit = 1'b1;
                hit_idx = wsel_w'(i);
            end
            if (!e_valid[i]) begin
                any_inv = 1'b1;
                inv_idx = wsel_w'(i);
            end
        end
        if (any_hit) begin
            sel = hit_idx;
        end else if (any_inv) begin
            sel = inv_idx;
        end else begin
            sel = repl_way;
        end
        // fresh entry starts from all zero counters
        base_ctrs = any_hit ? e_ctrs[sel] : {ctrs{pred_pkg::CTR_INIT}};
        new_ctrs = base_ctrs;
        new_ctrs[upd_h_q] = pred_pkg::ctr_step(base_ctrs[upd_h_q], upd_taken_q);
    end

    // init sweep owns the write port while active
    always_comb begin
        if (clear_en) begin
            we_vec   = '1;
            wr_addr  = clear_addr;
            wr_valid = 1'b0;
            wr_tag   = '0;
            wr_ctrs  = '0;
        end else begin
            we_vec = '0;
            if (upd_vld_q) begin
                we_vec[sel] = 1'b1;
            end
            wr_addr  = upd_addr_q;
            wr_valid = 1'b1;
            wr_tag   = upd_tag_q;
            wr_ctrs  = new_ctrs;
        end
    end

    assign repl_step = upd_vld_q && !any_hit && !any_inv;  // only when evicting

endmodule

// File: pred_cache/pred_replace.sv
`timescale 1ns/100ps

module pred_replace #(
    parameter int addr_width = pred_pkg::ADDR_WIDTH_DEF,
    parameter int way        = pred_pkg::WAYS_DEF
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [addr_width-1:0]   repl_addr,
    input  logic                    repl_step,
    output logic [$clog2(way)-1:0]  repl_way
);

    localparam int sets   = 1 << addr_width;
    localparam int wsel_w = $clog2(way);

    logic [wsel_w-1:0] ptr [sets];  // next victim per set

    assign repl_way = ptr[repl_addr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < sets; s++) begin
                ptr[s] <= '0;
            end
        end else if (repl_step) begin
            if (ptr[repl_addr] == wsel_w'(way - 1)) begin
                ptr[repl_addr] <= '0;  // wrap for any way count
            end else begin
                ptr[repl_addr] <= ptr[repl_addr] + 1'b1;
            end
        end
    end

endmodule

// File: pred_cache/pred_way_ram.sv
`timescale 1ns/100ps

module pred_way_ram #(
    parameter int addr_width = pred_pkg::ADDR_WIDTH_DEF,
    parameter int tag_width  = pred_pkg::TAG_WIDTH_DEF,
    parameter int h_width    = pred_pkg::H_WIDTH_DEF
) (
    input logic     clk,
    pred_way_if.ram wp
);

    localparam int sets = 1 << addr_width;
    localparam int ctrs = 1 << h_width;

    // one entry per set, split by field
    logic                      valid_mem [sets];
    logic [tag_width-1:0]      tag_mem   [sets];
    pred_pkg::ctr_t [ctrs-1:0] ctr_mem   [sets];

    // lookup port
    always_ff @(posedge clk) begin
        wp.rvalid <= valid_mem[wp.raddr];
        wp.rtag   <= tag_mem[wp.raddr];
        wp.rctrs  <= ctr_mem[wp.raddr];
    end

    // update read port, old data on a same-edge write
    always_ff @(posedge clk) begin
        wp.uvalid <= valid_mem[wp.uaddr];
        wp.utag   <= tag_mem[wp.uaddr];
        wp.uctrs  <= ctr_mem[wp.uaddr];
    end

    always_ff @(posedge clk) begin
        if (wp.we) begin
            valid_mem[wp.waddr] <= wp.wvalid;
            tag_mem[wp.waddr]   <= wp.wtag;
            ctr_mem[wp.waddr]   <= wp.wctrs;
        end
    end

endmodule

// File: common/pred_way_if.sv
`timescale 1ns/100ps

interface pred_way_if #(
    parameter int addr_width = pred_pkg::ADDR_WIDTH_DEF,
    parameter int tag_width  = pred_pkg::TAG_WIDTH_DEF,
    parameter int h_width    = pred_pkg::H_WIDTH_DEF
) ();

    logic [addr_width-1:0]                 raddr;  // lookup read
    logic [addr_width-1:0]                 uaddr;  // read for update
    logic [addr_width-1:0]                 waddr;
    logic                                  we;
    logic                                  wvalid;
    logic [tag_width-1:0]                  wtag;
    pred_pkg::ctr_t [(1 << h_width)-1:0]   wctrs;

    logic                                  rvalid;
    logic [tag_width-1:0]                  rtag;
    pred_pkg::ctr_t [(1 << h_width)-1:0]   rctrs;
    logic                                  uvalid;
    logic [tag_width-1:0]                  utag;
    pred_pkg::ctr_t [(1 << h_width)-1:0]   uctrs;

    modport cache (
        output raddr, uaddr, waddr, we, wvalid, wtag, wctrs,
        input  rvalid, rtag, rctrs, uvalid, utag, uctrs
    );

    modport ram (
        input  raddr, uaddr, waddr, we, wvalid, wtag, wctrs,
        output rvalid, rtag, rctrs, uvalid, utag, uctrs
    );

endinterface

// File: common/pred_pkg.sv
package pred_pkg;

    localparam int ADDR_WIDTH_DEF = 6;  // 64 sets
    localparam int TAG_WIDTH_DEF  = 10;
    localparam int H_WIDTH_DEF    = 4;  // 16 counters per entry
    localparam int WAYS_DEF       = 4;

    // 2-bit saturating counter, msb gives the direction
    typedef logic [1:0] ctr_t;

    // strongly not taken, also what a miss predicts
    localparam ctr_t CTR_INIT = 2'b00;

    // one step toward 11 on taken, toward 00 otherwise
    function automatic ctr_t ctr_step(input ctr_t ctr, input logic taken);
        ctr_t nxt;
        nxt = ctr;
        if (taken && ctr != 2'b11) begin
            nxt = ctr + 2'd1;
        end else if (!taken && ctr != 2'b00) begin
            nxt = ctr - 2'd1;
        end
        return nxt;
    endfunction

endpackage
